// File: logic/frv_csr_consts.svh
/*
 * Machine-mode CSR constants
 * Register width, CSR addresses, select bit positions, legal trap
 * cause codes and the fixed register values
 */
`ifndef FRV_CSR_CONSTS_SVH
`define FRV_CSR_CONSTS_SVH

`define XLEN                32

// Standard machine-mode CSR addresses
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MEDELEG    12'h302
`define CSR_ADDR_MIDELEG    12'h303
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MTVAL      12'h343
`define CSR_ADDR_MIP        12'h344
`define CSR_ADDR_MVENDORID  12'hF11
`define CSR_ADDR_MARCHID    12'hF12
`define CSR_ADDR_MIMPID     12'hF13
`define CSR_ADDR_MHARTID    12'hF14

// Bit positions in a one-hot select vector
`define CSR_SEL_MSTATUS     0
`define CSR_SEL_MISA        1
`define CSR_SEL_MEDELEG     2
`define CSR_SEL_MIDELEG     3
`define CSR_SEL_MIE         4
`define CSR_SEL_MTVEC       5
`define CSR_SEL_MSCRATCH    6
`define CSR_SEL_MEPC        7
`define CSR_SEL_MCAUSE      8
`define CSR_SEL_MTVAL       9
`define CSR_SEL_MIP         10
`define CSR_SEL_MVENDORID   11
`define CSR_SEL_MARCHID     12
`define CSR_SEL_MIMPID      13
`define CSR_SEL_MHARTID     14
`define CSR_NUM_SEL         15

// Exception codes software may write to mcause
`define TRAP_IALIGN         6'd0
`define TRAP_IACCESS        6'd1
`define TRAP_IOPCODE        6'd2
`define TRAP_BREAKPT        6'd3
`define TRAP_LDALIGN        6'd4
`define TRAP_LDACCESS       6'd5
`define TRAP_STALIGN        6'd6
`define TRAP_STACCESS       6'd7
`define TRAP_ECALLM         6'd11

`define CSR_MISA_VALUE      32'h4000_1100   // MXL=1, I and M
`define CSR_MTVEC_RESET     32'hC000_0000
`define CSR_MVENDORID       32'h0000_0000
`define CSR_MARCHID         32'h0000_0000
`define CSR_MIMPID          32'h0000_0000
`define CSR_MHARTID         32'h0000_0000

`endif

// File: logic/frv_csr_pkg.sv
/*
 * Machine-mode CSR types
 * Vector typedefs shared by the CSR register file blocks
 */
`include "frv_csr_consts.svh"

package frv_csr_pkg;

    // One register or data word
    typedef logic [`XLEN-1:0] xlen_t;

    // 12-bit CSR address from the instruction
    typedef logic [11:0] csr_addr_t;

    // Exception or interrupt code from the core
    typedef logic [5:0] trap_cause_t;

    // One bit per implemented CSR
    typedef logic [`CSR_NUM_SEL-1:0] csr_sel_t;

endpackage

// File: logic/frv_csr_decode.sv
/*
 * CSR address decoder
 * Matches the access address against the implemented CSRs and
 * produces one-hot read and write selects
 */
`timescale 1ns/1ps
`include "frv_csr_consts.svh"

module frv_csr_decode (
    input  logic                  csr_en,
    input  logic                  csr_wr,
    input  frv_csr_pkg::csr_addr_t csr_addr,
    output frv_csr_pkg::csr_sel_t  rd_sel,
    output frv_csr_pkg::csr_sel_t  wr_sel
);

    import frv_csr_pkg::*;

    csr_sel_t addr_match;   // Ungated one-hot match

    //--------------------------------------------------
    // Address match
    //--------------------------------------------------
    always_comb begin
        addr_match = '0;
        case (csr_addr)
            `CSR_ADDR_MSTATUS:   addr_match[`CSR_SEL_MSTATUS]   = 1'b1;
            `CSR_ADDR_MISA:      addr_match[`CSR_SEL_MISA]      = 1'b1;
            `CSR_ADDR_MEDELEG:   addr_match[`CSR_SEL_MEDELEG]   = 1'b1;
            `CSR_ADDR_MIDELEG:   addr_match[`CSR_SEL_MIDELEG]   = 1'b1;
            `CSR_ADDR_MIE:       addr_match[`CSR_SEL_MIE]       = 1'b1;
            `CSR_ADDR_MTVEC:     addr_match[`CSR_SEL_MTVEC]     = 1'b1;
            `CSR_ADDR_MSCRATCH:  addr_match[`CSR_SEL_MSCRATCH]  = 1'b1;
            `CSR_ADDR_MEPC:      addr_match[`CSR_SEL_MEPC]      = 1'b1;
            `CSR_ADDR_MCAUSE:    addr_match[`CSR_SEL_MCAUSE]    = 1'b1;
            `CSR_ADDR_MTVAL:     addr_match[`CSR_SEL_MTVAL]     = 1'b1;
            `CSR_ADDR_MIP:       addr_match[`CSR_SEL_MIP]       = 1'b1;
            `CSR_ADDR_MVENDORID: addr_match[`CSR_SEL_MVENDORID] = 1'b1;
            `CSR_ADDR_MARCHID:   addr_match[`CSR_SEL_MARCHID]   = 1'b1;
            `CSR_ADDR_MIMPID:    addr_match[`CSR_SEL_MIMPID]    = 1'b1;
            `CSR_ADDR_MHARTID:   addr_match[`CSR_SEL_MHARTID]   = 1'b1;
            default:             addr_match                     = '0; // Unknown, reads 0
        endcase
    end

    //--------------------------------------------------
    // Enable gating
    //--------------------------------------------------
    // Read-only registers still get write select bits here,
    // the register blocks simply have nothing behind them
    assign rd_sel = addr_match & {`CSR_NUM_SEL{csr_en}};
    assign wr_sel = addr_match & {`CSR_NUM_SEL{csr_wr}};

endmodule

// File: logic/frv_csr_trap_regs.sv
/*
 * Trap state registers
 * Holds mstatus, mepc, mcause and mtval and applies trap entry,
 * MRET and software writes in that order of priority
 */
`timescale 1ns/1ps
`include "frv_csr_consts.svh"

module frv_csr_trap_regs (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  frv_csr_pkg::csr_sel_t    wr_sel,
    input  logic                     csr_wr_set,
    input  logic                     csr_wr_clr,
    input  frv_csr_pkg::xlen_t       csr_wdata,
    input  logic                     exec_mret,
    input  logic                     trap_cpu,
    input  logic                     trap_int,
    input  frv_csr_pkg::trap_cause_t trap_cause,
    input  frv_csr_pkg::xlen_t       trap_mtval,
    input  frv_csr_pkg::xlen_t       trap_pc,
    output frv_csr_pkg::xlen_t       mstatus,
    output frv_csr_pkg::xlen_t       mepc,
    output frv_csr_pkg::xlen_t       mcause,
    output frv_csr_pkg::xlen_t       mtval
);

    import frv_csr_pkg::*;

    // Full, set or clear write of one register
    function automatic xlen_t csr_merge(
        input xlen_t old_val,
        input xlen_t wdata,
        input logic  wr_set,
        input logic  wr_clr
    );
        return wr_set ? (old_val | wdata) :
               wr_clr ? (old_val & ~wdata) :
                        wdata;
    endfunction

    logic             mie_q;
    logic             mpie_q;
    logic             wpri2_q;         // mstatus bit 2
    logic             wpri6_q;         // mstatus bit 6
    logic [1:0]       wpri10_9_q;
    logic [7:0]       wpri30_23_q;
    logic [`XLEN-1:1] mepc_q;          // Bit 0 always reads 0
    xlen_t            mcause_q;
    xlen_t            mtval_q;

    logic  trap_any;
    logic  mcause_legal;
    xlen_t mstatus_wr;
    xlen_t mepc_wr;
    xlen_t mcause_wr;
    xlen_t mtval_wr;

    assign trap_any = trap_int | trap_cpu;

    // RV32 mstatus layout, unimplemented fields tied to 0
    assign mstatus = {1'b0, wpri30_23_q, 12'b0, wpri10_9_q, 1'b0,
                      mpie_q, wpri6_q, 2'b0, mie_q, wpri2_q, 2'b0};
    assign mepc    = {mepc_q, 1'b0};
    assign mcause  = mcause_q;
    assign mtval   = mtval_q;

    assign mstatus_wr = csr_merge(mstatus, csr_wdata, csr_wr_set, csr_wr_clr);
    assign mepc_wr    = csr_merge(mepc,    csr_wdata, csr_wr_set, csr_wr_clr);
    assign mcause_wr  = csr_merge(mcause,  csr_wdata, csr_wr_set, csr_wr_clr);
    assign mtval_wr   = csr_merge(mtval,   csr_wdata, csr_wr_set, csr_wr_clr);

    // Only exact cause codes are taken, so bit 31 ends up clear
    assign mcause_legal = mcause_wr inside {
        xlen_t'(`TRAP_IALIGN),  xlen_t'(`TRAP_IACCESS), xlen_t'(`TRAP_IOPCODE),
        xlen_t'(`TRAP_BREAKPT), xlen_t'(`TRAP_LDALIGN), xlen_t'(`TRAP_LDACCESS),
        xlen_t'(`TRAP_STALIGN), xlen_t'(`TRAP_STACCESS), xlen_t'(`TRAP_ECALLM)
    };

    //--------------------------------------------------
    // mstatus
    //--------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mie_q       <= 1'b0;
            mpie_q      <= 1'b0;
            wpri2_q     <= 1'b0;
            wpri6_q     <= 1'b0;
            wpri10_9_q  <= '0;
            wpri30_23_q <= '0;
        end else if (trap_any) begin
            mpie_q <= mie_q;        // Stack the enable
            mie_q  <= 1'b0;
        end else if (exec_mret) begin
            mie_q  <= mpie_q;       // Pop the enable
            mpie_q <= 1'b0;
        end else if (wr_sel[`CSR_SEL_MSTATUS]) begin
            mie_q       <= mstatus_wr[3];
            mpie_q      <= mstatus_wr[7];
            wpri2_q     <= mstatus_wr[2];
            wpri6_q     <= mstatus_wr[6];
            wpri10_9_q  <= mstatus_wr[10:9];
            wpri30_23_q <= mstatus_wr[30:23];
        end
    end

    //--------------------------------------------------
    // mepc, mcause, mtval
    //--------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mepc_q <= '0;
        end else if (trap_any) begin
            mepc_q <= trap_pc[`XLEN-1:1];
        end else if (wr_sel[`CSR_SEL_MEPC]) begin
            mepc_q <= mepc_wr[`XLEN-1:1];
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mcause_q <= '0;
        end else if (trap_any) begin
            mcause_q <= {trap_int, {(`XLEN-7){1'b0}}, trap_cause};
        end else if (wr_sel[`CSR_SEL_MCAUSE] && mcause_legal) begin
            mcause_q <= mcause_wr;
        end
    end

    // Interrupts carry no trap value
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtval_q <= '0;
        end else if (trap_cpu) begin
            mtval_q <= trap_mtval;
        end else if (wr_sel[`CSR_SEL_MTVAL]) begin
            mtval_q <= mtval_wr;
        end
    end

endmodule

// File: logic/frv_csr_machine_regs.sv
/*
 * Machine trap setup registers
 * Holds mtvec (direct mode only) and mscratch
 */
`timescale 1ns/1ps
`include "frv_csr_consts.svh"

module frv_csr_machine_regs (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  frv_csr_pkg::csr_sel_t wr_sel,
    input  logic                  csr_wr_set,
    input  logic                  csr_wr_clr,
    input  frv_csr_pkg::xlen_t    csr_wdata,
    output frv_csr_pkg::xlen_t    mtvec,
    output frv_csr_pkg::xlen_t    mscratch
);

    import frv_csr_pkg::*;

    localparam xlen_t MTVEC_RESET = `CSR_MTVEC_RESET;

    function automatic xlen_t csr_merge(
        input xlen_t old_val,
        input xlen_t wdata,
        input logic  wr_set,
        input logic  wr_clr
    );
        return wr_set ? (old_val | wdata) :
               wr_clr ? (old_val & ~wdata) :
                        wdata;
    endfunction

    logic [`XLEN-1:2] mtvec_base_q;
    xlen_t            mscratch_q;
    xlen_t            mtvec_wr;
    xlen_t            mscratch_wr;

    assign mtvec    = {mtvec_base_q, 2'b00};   // Mode 00, direct
    assign mscratch = mscratch_q;

    assign mtvec_wr    = csr_merge(mtvec,    csr_wdata, csr_wr_set, csr_wr_clr);
    assign mscratch_wr = csr_merge(mscratch, csr_wdata, csr_wr_set, csr_wr_clr);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtvec_base_q <= MTVEC_RESET[`XLEN-1:2];
        end else if (wr_sel[`CSR_SEL_MTVEC]) begin
            mtvec_base_q <= mtvec_wr[`XLEN-1:2];
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mscratch_q <= '0;
        end else if (wr_sel[`CSR_SEL_MSCRATCH]) begin
            mscratch_q <= mscratch_wr;
        end
    end

endmodule

// File: logic/frv_csr_read_mux.sv
/*
 * CSR read multiplexer
 * Forms the constant and zero registers and ORs together every
 * register image gated by its read select
 */
`timescale 1ns/1ps
`include "frv_csr_consts.svh"

module frv_csr_read_mux (
    input  frv_csr_pkg::csr_sel_t rd_sel,
    input  frv_csr_pkg::xlen_t    mstatus,
    input  frv_csr_pkg::xlen_t    mtvec,
    input  frv_csr_pkg::xlen_t    mscratch,
    input  frv_csr_pkg::xlen_t    mepc,
    input  frv_csr_pkg::xlen_t    mcause,
    input  frv_csr_pkg::xlen_t    mtval,
    output frv_csr_pkg::xlen_t    csr_rdata
);

    import frv_csr_pkg::*;

    xlen_t reg_img [`CSR_NUM_SEL];  // Indexed by select bit

    //--------------------------------------------------
    // Register images
    //--------------------------------------------------
    always_comb begin
        reg_img[`CSR_SEL_MSTATUS]   = mstatus;
        reg_img[`CSR_SEL_MISA]      = `CSR_MISA_VALUE;
        reg_img[`CSR_SEL_MEDELEG]   = '0;     // No delegation
        reg_img[`CSR_SEL_MIDELEG]   = '0;
        reg_img[`CSR_SEL_MIE]       = '0;     // No interrupt enables
        reg_img[`CSR_SEL_MTVEC]     = mtvec;
        reg_img[`CSR_SEL_MSCRATCH]  = mscratch;
        reg_img[`CSR_SEL_MEPC]      = mepc;
        reg_img[`CSR_SEL_MCAUSE]    = mcause;
        reg_img[`CSR_SEL_MTVAL]     = mtval;
        reg_img[`CSR_SEL_MIP]       = '0;     // Nothing pending
        reg_img[`CSR_SEL_MVENDORID] = `CSR_MVENDORID;
        reg_img[`CSR_SEL_MARCHID]   = `CSR_MARCHID;
        reg_img[`CSR_SEL_MIMPID]    = `CSR_MIMPID;
        reg_img[`CSR_SEL_MHARTID]   = `CSR_MHARTID;
    end

    //--------------------------------------------------
    // AND-OR select
    //--------------------------------------------------
    // Selects are one-hot, no select gives 0
    always_comb begin
        csr_rdata = '0;
        for (int i = 0; i < `CSR_NUM_SEL; i++) begin
            csr_rdata = csr_rdata | (reg_img[i] & {`XLEN{rd_sel[i]}});
        end
    end

endmodule

// File: logic/frv_csrs.sv
/*
 * Machine-mode CSR file
 * Top level of the core's control and status registers, reached
 * from execute through the CSR access port
 */
`timescale 1ns/1ps

module frv_csrs (
    input  logic                     g_clk,
    input  logic                     g_resetn,

    // Access port from execute
    input  logic                     csr_en,
    input  logic                     csr_wr,
    input  logic                     csr_wr_set,
    input  logic                     csr_wr_clr,
    input  frv_csr_pkg::csr_addr_t   csr_addr,
    input  frv_csr_pkg::xlen_t       csr_wdata,
    output frv_csr_pkg::xlen_t       csr_rdata,

    output frv_csr_pkg::xlen_t       csr_mepc,    // Return target for MRET
    output frv_csr_pkg::xlen_t       csr_mtvec,   // Trap vector

    input  logic                     exec_mret,

    // Trap entry
    input  logic                     trap_cpu,
    input  logic                     trap_int,
    input  frv_csr_pkg::trap_cause_t trap_cause,
    input  frv_csr_pkg::xlen_t       trap_mtval,
    input  frv_csr_pkg::xlen_t       trap_pc
);

    import frv_csr_pkg::*;

    csr_sel_t rd_sel;
    csr_sel_t wr_sel;
    xlen_t    mstatus;
    xlen_t    mtvec;
    xlen_t    mscratch;
    xlen_t    mepc;
    xlen_t    mcause;
    xlen_t    mtval;

    frv_csr_decode i_decode (
        .csr_en   (csr_en),
        .csr_wr   (csr_wr),
        .csr_addr (csr_addr),
        .rd_sel   (rd_sel),
        .wr_sel   (wr_sel)
    );

    frv_csr_trap_regs i_trap_regs (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .wr_sel     (wr_sel),
        .csr_wr_set (csr_wr_set),
        .csr_wr_clr (csr_wr_clr),
        .csr_wdata  (csr_wdata),
        .exec_mret  (exec_mret),
        .trap_cpu   (trap_cpu),
        .trap_int   (trap_int),
        .trap_cause (trap_cause),
        .trap_mtval (trap_mtval),
        .trap_pc    (trap_pc),
        .mstatus    (mstatus),
        .mepc       (mepc),
        .mcause     (mcause),
        .mtval      (mtval)
    );

    frv_csr_machine_regs i_machine_regs (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .wr_sel     (wr_sel),
        .csr_wr_set (csr_wr_set),
        .csr_wr_clr (csr_wr_clr),
        .csr_wdata  (csr_wdata),
        .mtvec      (mtvec),
        .mscratch   (mscratch)
    );

    frv_csr_read_mux i_read_mux (
        .rd_sel    (rd_sel),
        .mstatus   (mstatus),
        .mtvec     (mtvec),
        .mscratch  (mscratch),
        .mepc      (mepc),
        .mcause    (mcause),
        .mtval     (mtval),
        .csr_rdata (csr_rdata)
    );

    // Both come straight from registers
    assign csr_mepc  = mepc;
    assign csr_mtvec = mtvec;

endmodule

// File: test/tb_frv_csrs.sv
/*
 * Testbench for the machine-mode CSR file
 * Drives reads, writes, traps and MRET, and checks every cycle
 * against a register model
 */
`timescale 1ns/1ps
`include "frv_csr_consts.svh"

module tb_frv_csrs;

    // Budgeted cycles for reset and tests 1 to 6
    localparam int TEST_CYCLES = 12 + 20 + 100 + 10 + 16 + 40 + 44;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;
    localparam logic [31:0] MSTATUS_MASK = 32'h7F80_06CC;  // MIE, MPIE and WPRI

    localparam logic [11:0] KEPT_ADDRS [15] = '{
        `CSR_ADDR_MSTATUS, `CSR_ADDR_MISA, `CSR_ADDR_MEDELEG, `CSR_ADDR_MIDELEG,
        `CSR_ADDR_MIE, `CSR_ADDR_MTVEC, `CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC,
        `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL, `CSR_ADDR_MIP, `CSR_ADDR_MVENDORID,
        `CSR_ADDR_MARCHID, `CSR_ADDR_MIMPID, `CSR_ADDR_MHARTID
    };
    // Read-only, zero and unknown addresses (0xC00 is the dropped cycle counter)
    localparam logic [11:0] RO_ADDRS [11] = '{
        `CSR_ADDR_MISA, `CSR_ADDR_MEDELEG, `CSR_ADDR_MIDELEG, `CSR_ADDR_MIE,
        `CSR_ADDR_MIP, `CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID, `CSR_ADDR_MIMPID,
        `CSR_ADDR_MHARTID, 12'h7C0, 12'hC00
    };

    logic        g_clk;
    logic        g_resetn;
    logic        csr_en;
    logic        csr_wr;
    logic        csr_wr_set;
    logic        csr_wr_clr;
    logic [11:0] csr_addr;
    logic [31:0] csr_wdata;
    logic [31:0] csr_rdata;
    logic [31:0] csr_mepc;
    logic [31:0] csr_mtvec;
    logic        exec_mret;
    logic        trap_cpu;
    logic        trap_int;
    logic [5:0]  trap_cause;
    logic [31:0] trap_mtval;
    logic [31:0] trap_pc;

    // Model state
    logic [31:0] m_mstatus;
    logic [31:0] m_mtvec;
    logic [31:0] m_mscratch;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic [31:0] m_mtval;

    integer seed = 32'h1c37;
    int     error_count = 0;
    int     pass_count = 0;
    int     fail_count = 0;
    int     cycle_count = 0;

    frv_csrs i_frv_csrs (.*);

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;
    end

    always @(posedge g_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the tests never finished", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    //--------------------------------------------------
    // Reference model
    //--------------------------------------------------
    function automatic logic [31:0] expected_rdata(input logic [11:0] addr);
        case (addr)
            `CSR_ADDR_MSTATUS:  return m_mstatus;
            `CSR_ADDR_MISA:     return 32'h4000_1100;  // MXL=1, bits 8 and 12
            `CSR_ADDR_MTVEC:    return m_mtvec;
            `CSR_ADDR_MSCRATCH: return m_mscratch;
            `CSR_ADDR_MEPC:     return m_mepc;
            `CSR_ADDR_MCAUSE:   return m_mcause;
            `CSR_ADDR_MTVAL:    return m_mtval;
            default:            return 32'h0;          // IDs, zero regs, unknown
        endcase
    endfunction

    function automatic logic [31:0] merge_write(input logic [31:0] old_val);
        if (csr_wr_set) return old_val | csr_wdata;
        if (csr_wr_clr) return old_val & ~csr_wdata;
        return csr_wdata;
    endfunction

    function automatic logic write_to(input logic [11:0] addr);
        return csr_wr && (csr_addr == addr);
    endfunction

    function automatic logic legal_cause(input logic [31:0] value);
        return (value <= 32'd7) || (value == 32'd11);
    endfunction

    task automatic reset_model();
        m_mstatus  = 32'h0;
        m_mtvec    = 32'hC000_0000;
        m_mscratch = 32'h0;
        m_mepc     = 32'h0;
        m_mcause   = 32'h0;
        m_mtval    = 32'h0;
    endtask

    // Next state from the inputs of this cycle
    task automatic update_model();
        logic        trap;
        logic [31:0] cause_wr;
        trap = trap_int | trap_cpu;
        cause_wr = merge_write(m_mcause);
        if (trap)
            m_mstatus = (m_mstatus & ~32'h88) | {24'b0, m_mstatus[3], 7'b0};
        else if (exec_mret)
            m_mstatus = (m_mstatus & ~32'h88) | {28'b0, m_mstatus[7], 3'b0};
        else if (write_to(`CSR_ADDR_MSTATUS))
            m_mstatus = merge_write(m_mstatus) & MSTATUS_MASK;
        if (trap)
            m_mepc = {trap_pc[31:1], 1'b0};
        else if (write_to(`CSR_ADDR_MEPC))
            m_mepc = merge_write(m_mepc) & ~32'h1;
        if (trap)
            m_mcause = {trap_int, 25'b0, trap_cause};
        else if (write_to(`CSR_ADDR_MCAUSE) && legal_cause(cause_wr))
            m_mcause = cause_wr;
        if (trap_cpu)
            m_mtval = trap_mtval;
        else if (write_to(`CSR_ADDR_MTVAL))
            m_mtval = merge_write(m_mtval);
        if (write_to(`CSR_ADDR_MTVEC))
            m_mtvec = merge_write(m_mtvec) & ~32'h3;
        if (write_to(`CSR_ADDR_MSCRATCH))
            m_mscratch = merge_write(m_mscratch);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s expected %08h, actual %08h",
                     $time, name, expected, actual);
        end
    endtask

    // Compare 1 ns before each rising edge
    initial begin
        forever begin
            @(negedge g_clk);
            #3;
            if (!g_resetn) begin
                reset_model();
            end else begin
                check_value("csr_rdata", csr_en ? expected_rdata(csr_addr) : 32'h0, csr_rdata);
                check_value("csr_mepc", m_mepc, csr_mepc);
                check_value("csr_mtvec", m_mtvec, csr_mtvec);
                update_model();
            end
        end
    end

    //--------------------------------------------------
    // Stimulus
    //--------------------------------------------------
    task automatic drive_idle();
        csr_en     = 1'b0;
        csr_wr     = 1'b0;
        csr_wr_set = 1'b0;
        csr_wr_clr = 1'b0;
        csr_addr   = 12'h0;
        csr_wdata  = 32'h0;
        exec_mret  = 1'b0;
        trap_cpu   = 1'b0;
        trap_int   = 1'b0;
        trap_cause = 6'h0;
        trap_mtval = 32'h0;
        trap_pc    = 32'h0;
    endtask

    task automatic next_cycle();
        @(negedge g_clk);
        drive_idle();
    endtask

    task automatic csr_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic set, input logic clr);
        next_cycle();
        csr_en     = 1'b1;
        csr_wr     = 1'b1;
        csr_wr_set = set;
        csr_wr_clr = clr;
        csr_addr   = addr;
        csr_wdata  = data;
    endtask

    task automatic csr_read(input logic [11:0] addr);
        next_cycle();
        csr_en   = 1'b1;
        csr_addr = addr;
    endtask

    task automatic expect_read(input logic [11:0] addr, input string name,
                               input logic [31:0] expected);
        csr_read(addr);
        #1;
        check_value(name, expected, csr_rdata);
    endtask

    task automatic pulse_trap(input logic is_int, input logic [5:0] cause,
                              input logic [31:0] tval, input logic [31:0] pc);
        next_cycle();
        trap_int   = is_int;
        trap_cpu   = !is_int;
        trap_cause = cause;
        trap_mtval = tval;
        trap_pc    = pc;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        next_cycle();
        if (error_count == errors_before) begin
            pass_count++;
            $display("%0t ns: %s ok", $time, name);
        end else begin
            fail_count++;
            $display("%0t ns: %s FAILED, %0d mismatches", $time, name,
                     error_count - errors_before);
        end
    endtask

    initial begin
        int          errs;
        logic [31:0] rnd;
        logic [31:0] tval;
        logic [31:0] pc_val;
        logic [31:0] cause_exp;
        logic [11:0] addr;
        g_resetn = 1'b0;
        drive_idle();
        repeat (10) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;

        errs = error_count;
        for (int i = 0; i < 15; i++) csr_read(KEPT_ADDRS[i]);
        csr_read(12'h7C0);
        check_value("csr_mtvec", 32'hC000_0000, csr_mtvec);
        finish_test("reset_values", errs);

        // Random full, set and clear writes where set wins over clear
        errs = error_count;
        for (int n = 0; n < 48; n++) begin
            rnd = $random(seed);
            case (rnd % 32'd3)
                0:       addr = `CSR_ADDR_MSCRATCH;
                1:       addr = `CSR_ADDR_MTVEC;
                default: addr = `CSR_ADDR_MEPC;
            endcase
            csr_write(addr, $random(seed), rnd[4], rnd[5]);
            csr_read(addr);
            #1;
            if (addr == `CSR_ADDR_MTVEC)
                check_value("mtvec[1:0]", 32'h0, {30'h0, csr_rdata[1:0]});
            if (addr == `CSR_ADDR_MEPC)
                check_value("mepc[0]", 32'h0, {31'h0, csr_rdata[0]});
        end
        finish_test("random_writes", errs);

        errs = error_count;
        csr_write(`CSR_ADDR_MSTATUS, 32'h8, 1'b1, 1'b0);     // MIE on
        pc_val = $random(seed) | 32'h1;                      // Odd PC
        tval = $random(seed);
        pulse_trap(1'b0, `TRAP_IOPCODE, tval, pc_val);
        expect_read(`CSR_ADDR_MEPC, "mepc", pc_val & ~32'h1);
        expect_read(`CSR_ADDR_MCAUSE, "mcause", 32'd2);
        expect_read(`CSR_ADDR_MTVAL, "mtval", tval);
        expect_read(`CSR_ADDR_MSTATUS, "mstatus", 32'h80);
        finish_test("cpu_trap", errs);

        errs = error_count;
        csr_write(`CSR_ADDR_MSTATUS, 32'h8, 1'b1, 1'b0);
        expect_read(`CSR_ADDR_MSTATUS, "mstatus", 32'h88);  // MPIE kept by set write
        pulse_trap(1'b1, 6'd7, $random(seed), $random(seed));
        expect_read(`CSR_ADDR_MCAUSE, "mcause", 32'h8000_0007);
        expect_read(`CSR_ADDR_MTVAL, "mtval", tval);         // Untouched by interrupt
        expect_read(`CSR_ADDR_MSTATUS, "mstatus", 32'h80);
        next_cycle();
        exec_mret = 1'b1;
        expect_read(`CSR_ADDR_MSTATUS, "mstatus", 32'h08);
        pulse_trap(1'b0, `TRAP_ECALLM, 32'h0, 32'h0000_1234);
        csr_en    = 1'b1;                                    // Same-cycle mepc write loses
        csr_wr    = 1'b1;
        csr_addr  = `CSR_ADDR_MEPC;
        csr_wdata = 32'hDEAD_BEE0;
        expect_read(`CSR_ADDR_MEPC, "mepc", 32'h0000_1234);
        expect_read(`CSR_ADDR_MCAUSE, "mcause", 32'd11);
        finish_test("interrupt_and_mret", errs);

        errs = error_count;
        cause_exp = 32'd11;
        for (int c = 0; c <= 12; c++) begin
            if (c <= 7 || c == 11) cause_exp = c;
            csr_write(`CSR_ADDR_MCAUSE, c, 1'b0, 1'b0);
            expect_read(`CSR_ADDR_MCAUSE, "mcause", cause_exp);
        end
        for (int n = 0; n < 4; n++) begin
            csr_write(`CSR_ADDR_MCAUSE, $random(seed), 1'b0, 1'b0);
            csr_read(`CSR_ADDR_MCAUSE);
        end
        finish_test("mcause_filter", errs);

        errs = error_count;
        for (int i = 0; i < 11; i++) begin
            csr_write(RO_ADDRS[i], 32'hFFFF_FFFF, 1'b0, 1'b0);
            csr_read(RO_ADDRS[i]);
        end
        for (int i = 0; i < 15; i++) csr_read(KEPT_ADDRS[i]);
        expect_read(`CSR_ADDR_MISA, "misa", 32'h4000_1100);
        finish_test("read_only_writes", errs);

        $display("Summary: passed %0d, failed %0d, mismatches %0d",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+logic
logic/frv_csr_pkg.sv
logic/frv_csr_decode.sv
logic/frv_csr_trap_regs.sv
logic/frv_csr_machine_regs.sv
logic/frv_csr_read_mux.sv
logic/frv_csrs.sv
test/tb_frv_csrs.sv

// File: Makefile
# Verilator build and run of the CSR file testbench

TOP = tb_frv_csrs
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps \
		--top-module $(TOP) -f compile.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -qx "test passed" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
